/* Makefile */
TOP = amo_tb

.PHONY: lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o amo_sim
	@out="$$(./obj_dir/amo_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

/* sources.f */
src/amo_pkg.sv
src/amo_alu.sv
src/reservation_set.sv
src/amo_unit.sv
src/data_mem.sv
src/amo_top.sv
tb/amo_tb.sv

/* src/amo_alu.sv */
`timescale 1ns/1ns

module amo_alu (
    input  amo_pkg::amo_op_e           alu_op,
    input  logic [amo_pkg::XLEN-1:0]   alu_old,
    input  logic [amo_pkg::XLEN-1:0]   alu_operand,
    output logic [amo_pkg::XLEN-1:0]   alu_result
);
    import amo_pkg::*;

    logic less_signed;                    // old < operand, two's complement
    logic less_unsigned;                  // old < operand, magnitude

    assign less_signed   = $signed(alu_old) < $signed(alu_operand);
    assign less_unsigned = alu_old < alu_operand;

    always_comb begin
        case (alu_op)
            OP_SWAP: begin
                alu_result = alu_operand;
            end
            OP_ADD: begin
                alu_result = alu_old + alu_operand;
            end
            OP_AND: begin
                alu_result = alu_old & alu_operand;
            end
            OP_OR: begin
                alu_result = alu_old | alu_operand;
            end
            OP_XOR: begin
                alu_result = alu_old ^ alu_operand;
            end
            OP_MIN: begin
                alu_result = less_signed ? alu_old : alu_operand;
            end
            OP_MAX: begin
                alu_result = less_signed ? alu_operand : alu_old;
            end
            OP_MINU: begin
                alu_result = less_unsigned ? alu_old : alu_operand;
            end
            OP_MAXU: begin
                alu_result = less_unsigned ? alu_operand : alu_old;
            end
            default: begin
                // LR, SC, LW, SW leave the word as it was
                alu_result = alu_old;
            end
        endcase
    end

endmodule

/* src/amo_pkg.sv */
package amo_pkg;

    localparam int XLEN = 32;             // Data and address width
    localparam int OP_W = 5;              // Width of the funct5 field

    // Codes follow the RV32A funct5 field; LW and SW sit on unused codes
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 5'b00000,
        OP_SWAP = 5'b00001,
        OP_LR   = 5'b00010,
        OP_SC   = 5'b00011,
        OP_XOR  = 5'b00100,
        OP_LW   = 5'b00101,               // Plain load
        OP_SW   = 5'b00110,               // Plain store
        OP_OR   = 5'b01000,
        OP_AND  = 5'b01100,
        OP_MIN  = 5'b10000,
        OP_MAX  = 5'b10100,
        OP_MINU = 5'b11000,
        OP_MAXU = 5'b11100
    } amo_op_e;

    // Request from the core
    typedef struct packed {
        amo_op_e         op;
        logic [XLEN-1:0] addr;            // Byte address
        logic [XLEN-1:0] operand;         // rs2 value
    } amo_req_t;

    // Response to the core
    typedef struct packed {
        logic [XLEN-1:0] rdata;           // Value for rd
    } amo_resp_t;

    // Request to the data memory
    typedef struct packed {
        logic            read;
        logic            write;
        logic [XLEN-1:0] addr;            // Byte address
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

/* src/amo_top.sv */
`timescale 1ns/1ns

module amo_top #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  amo_pkg::amo_req_t     req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output amo_pkg::amo_resp_t    resp
);
    import amo_pkg::*;

    mem_req_t        mem_req;             // Unit to memory
    logic            mem_resp;
    logic [XLEN-1:0] mem_rdata;

    // Sequencer with its ALU and reservation tracker
    amo_unit u_unit (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata)
    );

    data_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata)
    );

endmodule

/* src/amo_unit.sv */
`timescale 1ns/1ns

module amo_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  amo_pkg::amo_req_t          req,
    output logic                       req_ready,
    output logic                       resp_valid,
    output amo_pkg::amo_resp_t         resp,
    output amo_pkg::mem_req_t          mem_req,
    input  logic                       mem_resp,
    input  logic [amo_pkg::XLEN-1:0]   mem_rdata
);
    import amo_pkg::*;

    typedef enum logic [2:0] {
        idle,
        load,
        calc,
        store,
        sc_write,
        done
    } state_e;

    state_e          state;
    state_e          next_state;
    amo_req_t        req_q;               // Request held for the whole operation
    amo_resp_t       resp_q;              // Answer for rd
    logic [XLEN-1:0] result_q;            // Word written in the store state
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] rsv_addr;
    logic            rsv_set;
    logic            rsv_clear;
    logic            store_seen;
    logic            rsv_hit;
    logic            accept;
    logic            read_only;           // LW or LR, no write phase

    assign accept    = req_valid && req_ready;
    assign read_only = (req_q.op == OP_LW) || (req_q.op == OP_LR);
    assign resp      = resp_q;

    // Incoming address while idle so the SC check sees the new request
    assign rsv_addr = (state == idle) ? req.addr : req_q.addr;

    amo_alu u_alu (
        .alu_op      (req_q.op),
        .alu_old     (resp_q.rdata),      // Loaded value sits in the response
        .alu_operand (req_q.operand),
        .alu_result  (alu_result)
    );

    reservation_set u_rsv (
        .clk        (clk),
        .rst        (rst),
        .rsv_set    (rsv_set),
        .rsv_clear  (rsv_clear),
        .store_seen (store_seen),
        .addr       (rsv_addr),
        .rsv_hit    (rsv_hit)
    );

    always_comb begin
        next_state   = state;
        req_ready    = 1'b0;
        resp_valid   = 1'b0;
        rsv_set      = 1'b0;
        rsv_clear    = 1'b0;
        store_seen   = 1'b0;
        mem_req      = '0;
        mem_req.addr = req_q.addr;

        case (state)
            idle: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    case (req.op)
                        OP_LW, OP_LR: next_state = load;
                        OP_SW:        next_state = store;
                        OP_SC: begin
                            if (rsv_hit) begin
                                next_state = sc_write;
                            end else begin
                                next_state = done;     // Failed SC, no memory access
                            end
                        end
                        default:      next_state = load;   // AMO read first
                    endcase
                end
            end
            load: begin
                mem_req.read = 1'b1;
                if (mem_resp) begin
                    rsv_set = (req_q.op == OP_LR);
                    if (read_only) begin
                        next_state = done;
                    end else begin
                        next_state = calc;
                    end
                end
            end
            calc: begin
                next_state = store;
            end
            store: begin
                mem_req.write = 1'b1;
                mem_req.wdata = result_q;
                if (mem_resp) begin
                    store_seen = 1'b1;
                    next_state = done;
                end
            end
            sc_write: begin
                mem_req.write = 1'b1;
                mem_req.wdata = req_q.operand;
                if (mem_resp) begin
                    store_seen = 1'b1;
                    next_state = done;
                end
            end
            done: begin
                resp_valid = 1'b1;
                rsv_clear  = (req_q.op == OP_SC);   // SC always ends the reservation
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            resp_q <= '0;
        end else begin
            state <= next_state;
            if (accept) begin
                // 1 only for a failed SC; SW and a good SC answer 0
                resp_q.rdata <= (req.op == OP_SC && !rsv_hit) ? XLEN'(1) : '0;
            end else if (state == load && mem_resp) begin
                resp_q.rdata <= mem_rdata;  // Old value for rd and the ALU
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q    <= req;
            result_q <= req.operand;        // SW data
        end else if (state == calc) begin
            result_q <= alu_result;
        end
    end

endmodule

/* src/data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_WORDS   = 256,      // Depth in words
    parameter int MEM_LATENCY = 2         // Request to mem_resp, at least 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  amo_pkg::mem_req_t          mem_req,
    output logic                       mem_resp,
    output logic [amo_pkg::XLEN-1:0]   mem_rdata
);
    import amo_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [XLEN-3:0]  word_addr;          // Address without the byte offset
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] cnt;                // Cycles spent on the current request
    logic             active;

    assign active    = mem_req.read || mem_req.write;
    assign word_addr = mem_req.addr[XLEN-1:2];
    assign idx       = IDX_W'(word_addr % MEM_WORDS);   // Wraps at the array depth

    // Last cycle of the request window
    assign mem_resp = active && (cnt == CNT_W'(MEM_LATENCY - 1));

    assign mem_rdata = (mem_resp && mem_req.read) ? mem[idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (mem_resp) begin
            cnt <= '0;                    // Ready for the next request
        end else if (active) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_resp && mem_req.write) begin
            mem[idx] <= mem_req.wdata;    // Lands with the response
        end
    end

endmodule

/* src/reservation_set.sv */
`timescale 1ns/1ns

module reservation_set (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rsv_set,
    input  logic                       rsv_clear,
    input  logic                       store_seen,
    input  logic [amo_pkg::XLEN-1:0]   addr,
    output logic                       rsv_hit
);
    import amo_pkg::*;

    logic            rsv_valid;           // Reservation is live
    logic [XLEN-3:0] rsv_word;            // Reserved word address
    logic            word_match;

    assign word_match = (addr[XLEN-1:2] == rsv_word);
    assign rsv_hit    = rsv_valid && word_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsv_valid <= 1'b0;
        end else if (rsv_set) begin
            rsv_valid <= 1'b1;
        end else if (rsv_clear || (store_seen && word_match)) begin
            // Any store to the reserved word breaks the reservation
            rsv_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsv_set) begin
            rsv_word <= addr[XLEN-1:2];   // Byte offset ignored
        end
    end

endmodule

/* tb/amo_tb.sv */
`timescale 1ns/1ns

module amo_tb;
    import amo_pkg::*;

    localparam int LAT        = 2;            // Memory latency of the DUT
    localparam int MAX_CYCLES = 4000;         // About 150 requests, 6 cycles each, margin

    logic      clk;
    logic      rst;
    logic      req_valid;
    amo_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    amo_resp_t resp;

    integer      seed = 32'h5ab97b32;
    logic [31:0] ref_mem [16];                // Expected memory contents
    logic        ref_rsv_valid;
    int          ref_rsv_word;
    logic [31:0] exp_rdata;                   // Expected answer of the pending request
    int          exp_lat;                     // Expected cycles from accept to resp_valid
    int          in_flight;
    int          lat_cnt;
    int          accepts;
    int          resps;
    int          issued;
    int          cycles;
    int          value_errors;
    int          protocol_errors;

    amo_op_e amo_ops [9] = '{OP_SWAP, OP_ADD, OP_AND, OP_OR, OP_XOR,
                             OP_MIN, OP_MAX, OP_MINU, OP_MAXU};

    amo_top #(
        .MEM_WORDS   (256),
        .MEM_LATENCY (LAT)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Handshake bookkeeping
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst) begin
            in_flight <= 0;
            lat_cnt   <= 0;
            accepts   <= 0;
            resps     <= 0;
        end else begin
            in_flight <= in_flight + ((req_valid && req_ready) ? 1 : 0) - (resp_valid ? 1 : 0);
            lat_cnt   <= (req_valid && req_ready) ? 1 : lat_cnt + 1;
            accepts   <= accepts + ((req_valid && req_ready) ? 1 : 0);
            resps     <= resps + (resp_valid ? 1 : 0);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    a_after_reset: assert property (@(posedge clk) $fell(rst) |-> req_ready && !resp_valid)
        else begin
            protocol_errors++;
            $display("Handshake after reset is wrong: req_ready low or resp_valid high");
        end

    a_resp_data: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp.rdata == exp_rdata)
        else begin
            value_errors++;
            $display("** Error at %0t: rdata %h, expected %h",
                     $time, $sampled(resp.rdata), $sampled(exp_rdata));
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> lat_cnt == exp_lat)
        else begin
            value_errors++;
            $display("** Error at %0t: latency %0d cycles, expected %0d",
                     $time, $sampled(lat_cnt), $sampled(exp_lat));
        end

    a_busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        in_flight != 0 |-> !req_ready)
        else begin
            protocol_errors++;
            $display("req_ready went high at %0t while a request was in flight", $time);
        end

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> in_flight == 1)
        else begin
            protocol_errors++;
            $display("resp_valid at %0t without exactly one accepted request", $time);
        end

    function automatic logic [31:0] apply_amo(amo_op_e op, logic [31:0] old, logic [31:0] opnd);
        logic [31:0] r;
        r = old;
        if (op == OP_SWAP) begin
            r = opnd;
        end else if (op == OP_ADD) begin
            r = old + opnd;
        end else if (op == OP_AND) begin
            r = old & opnd;
        end else if (op == OP_OR) begin
            r = old | opnd;
        end else if (op == OP_XOR) begin
            r = old ^ opnd;
        end else if (op == OP_MIN) begin
            r = ($signed(opnd) < $signed(old)) ? opnd : old;
        end else if (op == OP_MAX) begin
            r = ($signed(opnd) > $signed(old)) ? opnd : old;
        end else if (op == OP_MINU) begin
            r = (opnd < old) ? opnd : old;
        end else if (op == OP_MAXU) begin
            r = (opnd > old) ? opnd : old;
        end
        return r;
    endfunction

    // Updates the model, then runs one request through the handshake
    task automatic issue(input amo_op_e op, input int word, input logic [31:0] operand);
        logic [31:0] old;
        logic        hit;
        old = ref_mem[word];
        hit = ref_rsv_valid && (ref_rsv_word == word);
        if (op == OP_LW || op == OP_LR) begin
            exp_rdata = old;
            exp_lat   = LAT + 1;
            if (op == OP_LR) begin
                ref_rsv_valid = 1'b1;
                ref_rsv_word  = word;
            end
        end else if (op == OP_SW) begin
            exp_rdata     = 32'd0;
            exp_lat       = LAT + 1;
            ref_mem[word] = operand;
            if (hit) ref_rsv_valid = 1'b0;
        end else if (op == OP_SC) begin
            exp_rdata     = hit ? 32'd0 : 32'd1;
            exp_lat       = hit ? LAT + 1 : 1;
            ref_rsv_valid = 1'b0;
            if (hit) ref_mem[word] = operand;
        end else begin
            exp_rdata     = old;
            exp_lat       = 2 * LAT + 2;
            ref_mem[word] = apply_amo(op, old, operand);
            if (hit) ref_rsv_valid = 1'b0;
        end
        req_valid   = 1'b1;
        req.op      = op;
        req.addr    = 32'(word) << 2;
        req.operand = operand;
        while (!req_ready) @(negedge clk);
        @(negedge clk);                        // Accepted on the edge just passed
        req_valid = 1'b0;
        while (!resp_valid) @(negedge clk);
        @(negedge clk);
        issued++;
    endtask

    initial begin
        int w;
        req_valid       = 1'b0;
        req             = '0;
        rst             = 1'b1;
        ref_rsv_valid   = 1'b0;
        ref_rsv_word    = 0;
        exp_rdata       = '0;
        exp_lat         = 0;
        issued          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        issue(OP_SC, 0, 32'h1234_5678);        // No reservation yet, fast fail
        for (int i = 0; i < 16; i++) issue(OP_SW, i, $random(seed));
        for (int i = 0; i < 16; i++) issue(OP_LW, i, 32'd0);

        // Top bit set on one side so signed and unsigned compares disagree
        for (int i = 5; i < 9; i++) begin
            issue(OP_SW, 3, 32'h8000_0010);
            issue(amo_ops[i], 3, 32'h0000_0020);
            issue(OP_LW, 3, 32'd0);
            issue(OP_SW, 4, 32'h0000_0020);
            issue(amo_ops[i], 4, 32'h8000_0010);
            issue(OP_LW, 4, 32'd0);
        end

        for (int round = 0; round < 5; round++) begin
            for (int i = 0; i < 9; i++) begin
                w = {$random(seed)} % 16;
                issue(amo_ops[i], w, $random(seed));
                issue(OP_LW, w, 32'd0);
            end
        end

        // LR and SC pairs
        issue(OP_LR, 5, 32'd0);
        issue(OP_SC, 5, $random(seed));
        issue(OP_LW, 5, 32'd0);
        issue(OP_SC, 5, $random(seed));        // Reservation already used
        issue(OP_LW, 5, 32'd0);

        issue(OP_LR, 7, 32'd0);
        issue(OP_SW, 7, $random(seed));        // Breaks the reservation
        issue(OP_SC, 7, $random(seed));
        issue(OP_LW, 7, 32'd0);

        issue(OP_LR, 9, 32'd0);
        issue(OP_SW, 10, $random(seed));       // Other word, reservation holds
        issue(OP_SC, 9, $random(seed));
        issue(OP_LW, 9, 32'd0);

        issue(OP_LR, 11, 32'd0);
        issue(OP_ADD, 11, 32'd1);              // AMO store also breaks it
        issue(OP_SC, 11, $random(seed));
        issue(OP_LW, 11, 32'd0);

        repeat (2) @(negedge clk);
        a_counts: assert (accepts == issued && resps == issued)
            else begin
                protocol_errors++;
                $display("Request count mismatch: %0d issued, %0d accepted, %0d responses",
                         issued, accepts, resps);
            end

        $display("Errors: %0d value, %0d protocol, over %0d requests",
                 value_errors, protocol_errors, issued);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
